/* files.f */
+incdir+src
src/spec_pkg.sv
src/sdp_ram.sv
src/frame_tracker.sv
src/power_calc.sv
src/vector_acc.sv
src/spectrum_buffer.sv
src/spec_integrator.sv
bench/spec_integrator_props.sv
bench/spec_checker.sv
bench/spec_integrator_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := spec_integrator_tb
FILELIST  := files.f
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
SIM_ARGS  := +verilator+error+limit+100
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard src/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) $(SIM_ARGS) | tee $(LOG)
	@grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/spec_integrator_tb.sv */
`timescale 1ns/1ps
`include "spec_defines.svh"

module spec_integrator_tb;

    localparam int VLEN            = `SPEC_VECTOR_LEN;
    localparam int ACC_W           = `SPEC_ACC_W;
    localparam int MAX_SAMPLES     = 255 * VLEN;
    localparam int NUM_RESULTS     = 7;
    localparam int TOTAL_SAMPLES   = 40 + VLEN * (1 + 7 + 7 + 3 + 3 + 255);
    localparam int WATCHDOG_CYCLES = TOTAL_SAMPLES * 4 + 1000;

    logic                  clk = 1'b0;
    logic                  arst_n;
    logic                  start;
    spec_pkg::frame_cnt_t  acc_len;
    spec_pkg::sample_t     sample_re;
    spec_pkg::sample_t     sample_im;
    logic                  sample_valid;
    logic                  rd_en;
    spec_pkg::bin_t        rd_addr;
    spec_pkg::acc_t        rd_data;
    logic                  rd_valid;
    logic                  spec_ready;
    logic                  exp_push;
    int                    exp_id;
    logic [VLEN*ACC_W-1:0] exp_vec;
    logic                  quiet_end;
    int                    tests_run;
    int                    tests_failed;
    int                    errors;
    int                    re_buf [MAX_SAMPLES]; // Samples of the current integration.
    int                    im_buf [MAX_SAMPLES];

    always #4 clk = ~clk;

    spec_integrator spec_integrator_inst (
        .clk(clk), .arst_n(arst_n), .start(start), .acc_len(acc_len),
        .sample_re(sample_re), .sample_im(sample_im), .sample_valid(sample_valid),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data), .rd_valid(rd_valid),
        .spec_ready(spec_ready)
    );

    spec_checker spec_checker_inst (
        .clk(clk), .arst_n(arst_n), .spec_ready(spec_ready), .rd_valid(rd_valid),
        .rd_data(rd_data), .rd_en(rd_en), .rd_addr(rd_addr), .exp_push(exp_push),
        .exp_id(exp_id), .exp_vec(exp_vec), .quiet_end(quiet_end),
        .tests_run(tests_run), .tests_failed(tests_failed), .errors(errors)
    );

    // Power of one bin summed over all frames.
    function automatic int expected_sum(input int re_a [MAX_SAMPLES],
                                        input int im_a [MAX_SAMPLES],
                                        input int len, input int bin);
        int acc;
        int f;
        acc = 0;
        for (f = 0; f < len; f++) begin
            acc += re_a[f*VLEN+bin] * re_a[f*VLEN+bin] + im_a[f*VLEN+bin] * im_a[f*VLEN+bin];
        end
        return acc;
    endfunction

    task automatic run_integration(input int id, input int len, input bit gaps, input bit extreme);
        int i;
        start        = 1'b1;
        acc_len      = spec_pkg::frame_cnt_t'(len);
        sample_valid = 1'b0;
        @(negedge clk);
        start = 1'b0;
        for (i = 0; i < len * VLEN; i++) begin
            while (gaps && (($urandom % 4) == 0)) begin
                sample_valid = 1'b0;
                @(negedge clk);
            end
            if (extreme) begin
                re_buf[i] = (($urandom % 2) == 0) ? -128 : 127;
                im_buf[i] = (($urandom % 2) == 0) ? -128 : 127;
            end else begin
                re_buf[i] = int'($urandom % 256) - 128;
                im_buf[i] = int'($urandom % 256) - 128;
            end
            sample_re    = spec_pkg::sample_t'(re_buf[i]);
            sample_im    = spec_pkg::sample_t'(im_buf[i]);
            sample_valid = 1'b1;
            @(negedge clk);
        end
        sample_valid = 1'b0;
        for (i = 0; i < VLEN; i++) begin
            exp_vec[i*ACC_W +: ACC_W] = spec_pkg::acc_t'(expected_sum(re_buf, im_buf, len, i));
        end
        exp_id   = id;
        exp_push = 1'b1;
        @(negedge clk);
        exp_push = 1'b0;
    endtask

    // Samples with no start armed must never reach the result memory.
    task automatic send_unarmed(input int id, input int count);
        int i;
        for (i = 0; i < count; i++) begin
            sample_re    = spec_pkg::sample_t'($urandom);
            sample_im    = spec_pkg::sample_t'($urandom);
            sample_valid = 1'b1;
            @(negedge clk);
        end
        sample_valid = 1'b0;
        repeat (30) @(negedge clk);
        exp_id    = id;
        quiet_end = 1'b1;
        @(negedge clk);
        quiet_end = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h068a23b0));
        arst_n       = 1'b1;
        start        = 1'b0;
        acc_len      = 8'd1;
        sample_re    = '0;
        sample_im    = '0;
        sample_valid = 1'b0;
        exp_push     = 1'b0;
        exp_id       = 0;
        exp_vec      = '0;
        quiet_end    = 1'b0;
        @(negedge clk);
        arst_n = 1'b0;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        repeat (2) @(negedge clk);
        send_unarmed(1, 40);
        run_integration(2, 1, 1'b0, 1'b0);
        run_integration(3, 7, 1'b0, 1'b0);
        run_integration(4, 7, 1'b1, 1'b0);
        run_integration(5, 3, 1'b0, 1'b0); // Read while the next one fills.
        run_integration(6, 3, 1'b0, 1'b0);
        run_integration(7, 255, 1'b0, 1'b1);
        while (tests_run < NUM_RESULTS) @(negedge clk);
        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, spec_integrator_inst.props_inst.fail_cnt);
        if (errors == 0 && tests_failed == 0 && spec_integrator_inst.props_inst.fail_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles with %0d of %0d results checked, spec_ready never came",
                 WATCHDOG_CYCLES, tests_run, NUM_RESULTS);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* bench/spec_checker.sv */
`timescale 1ns/1ps
`include "spec_defines.svh"

module spec_checker (
    input  logic                                    clk,
    input  logic                                    arst_n,
    input  logic                                    spec_ready,
    input  logic                                    rd_valid,
    input  spec_pkg::acc_t                          rd_data,
    output logic                                    rd_en,
    output spec_pkg::bin_t                          rd_addr,
    input  logic                                    exp_push,
    input  int                                      exp_id,
    input  logic [`SPEC_VECTOR_LEN*`SPEC_ACC_W-1:0] exp_vec,
    input  logic                                    quiet_end,
    output int                                      tests_run,
    output int                                      tests_failed,
    output int                                      errors
);

    localparam int VLEN  = `SPEC_VECTOR_LEN;
    localparam int ACC_W = `SPEC_ACC_W;

    logic [VLEN*ACC_W-1:0] vec_q [$]; // Expected spectra in arrival order.
    int                    id_q [$];
    int                    stray_pulses;

    function automatic string test_name(input int id);
        case (id)
            1: return "no_start";
            2: return "single_frame";
            3: return "acc_len_7";
            4: return "random_gaps";
            5: return "back_to_back_a";
            6: return "back_to_back_b";
            7: return "extreme_acc_255";
            default: return "unknown";
        endcase
    endfunction

    task automatic close_test(input int id, input int bad);
        tests_run++;
        if (bad == 0) begin
            $display("test %0d %s: pass", id, test_name(id));
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL with %0d errors", id, test_name(id), bad);
        end
    endtask

    task automatic read_spectrum();
        logic [VLEN*ACC_W-1:0] vec;
        spec_pkg::acc_t        want;
        int                    id;
        int                    bad;
        int                    b;
        vec = vec_q.pop_front();
        id  = id_q.pop_front();
        bad = 0;
        for (b = 0; b < VLEN; b++) begin
            rd_en   = 1'b1;
            rd_addr = spec_pkg::bin_t'(b);
            @(negedge clk); // Data for this address is out now.
            want = vec[b*ACC_W +: ACC_W];
            if (!rd_valid) begin
                $display("read of bin %0d in test %s returned no rd_valid", b, test_name(id));
                bad++;
            end else if (rd_data !== want) begin
                $display("mismatch test %s bin %0d expected %0d actual %0d",
                         test_name(id), b, want, rd_data);
                bad++;
            end
        end
        rd_en  = 1'b0;
        errors += bad;
        close_test(id, bad);
    endtask

    always @(posedge clk) begin
        if (exp_push) begin
            vec_q.push_back(exp_vec);
            id_q.push_back(exp_id);
        end
    end

    initial begin
        rd_en        = 1'b0;
        rd_addr      = '0;
        tests_run    = 0;
        tests_failed = 0;
        errors       = 0;
        stray_pulses = 0;
        forever begin
            @(posedge clk);
            if (quiet_end) begin
                close_test(exp_id, stray_pulses);
            end
            @(negedge clk); // Flop outputs are settled mid-cycle.
            if (arst_n && spec_ready) begin
                if (id_q.size() == 0) begin
                    $display("spec_ready pulsed while no integration was pending");
                    stray_pulses++;
                    errors++;
                end else begin
                    read_spectrum();
                end
            end
        end
    end

endmodule

/* bench/spec_integrator_props.sv */
`timescale 1ns/1ps

module spec_integrator_props (
    input logic clk,
    input logic arst_n,
    input logic rd_en,
    input logic rd_valid,
    input logic spec_ready
);

    int fail_cnt = 0;

    ready_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        spec_ready |=> !spec_ready)
        else begin
            $error("spec_ready stayed high for more than one cycle");
            fail_cnt++;
        end

    read_valid_follows: assert property (@(posedge clk) disable iff (!arst_n)
        rd_en |=> rd_valid)
        else begin
            $error("rd_valid missing one cycle after rd_en");
            fail_cnt++;
        end

    read_valid_only_after_en: assert property (@(posedge clk) disable iff (!arst_n)
        !rd_en |=> !rd_valid)
        else begin
            $error("rd_valid high without a read one cycle earlier");
            fail_cnt++;
        end

    quiet_in_reset: assert property (@(posedge clk) !arst_n |-> (!spec_ready && !rd_valid))
        else begin
            $error("output valid while reset is asserted");
            fail_cnt++;
        end

endmodule

bind spec_integrator spec_integrator_props props_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_en     (rd_en),
    .rd_valid  (rd_valid),
    .spec_ready(spec_ready)
);

/* src/spec_integrator.sv */
`timescale 1ns/1ps

module spec_integrator (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 start,
    input  spec_pkg::frame_cnt_t acc_len,
    input  spec_pkg::sample_t    sample_re,
    input  spec_pkg::sample_t    sample_im,
    input  logic                 sample_valid,
    input  logic                 rd_en,
    input  spec_pkg::bin_t       rd_addr,
    output spec_pkg::acc_t       rd_data,
    output logic                 rd_valid,
    output logic                 spec_ready
);

    spec_pkg::bin_t   trk_bin;
    logic             trk_first;
    logic             trk_last;
    spec_pkg::power_t pwr;
    logic             pwr_valid;
    spec_pkg::bin_t   pwr_bin;
    logic             pwr_first;
    logic             pwr_last;
    spec_pkg::acc_t   sum;
    spec_pkg::bin_t   sum_bin;
    logic             sum_valid;

    frame_tracker frame_tracker_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (start),
        .acc_len     (acc_len),
        .sample_valid(sample_valid),
        .bin         (trk_bin),
        .first_frame (trk_first),
        .last_frame  (trk_last)
    );

    power_calc power_calc_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .sample_re   (sample_re),
        .sample_im   (sample_im),
        .sample_valid(sample_valid),
        .bin_in      (trk_bin),
        .first_in    (trk_first),
        .last_in     (trk_last),
        .pwr         (pwr),
        .pwr_valid   (pwr_valid),
        .bin         (pwr_bin),
        .first_frame (pwr_first),
        .last_frame  (pwr_last)
    );

    vector_acc vector_acc_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .pwr        (pwr),
        .pwr_valid  (pwr_valid),
        .bin        (pwr_bin),
        .first_frame(pwr_first),
        .last_frame (pwr_last),
        .sum        (sum),
        .sum_bin    (sum_bin),
        .sum_valid  (sum_valid)
    );

    spectrum_buffer spectrum_buffer_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .sum       (sum),
        .sum_bin   (sum_bin),
        .sum_valid (sum_valid),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .spec_ready(spec_ready)
    );

endmodule

/* src/spectrum_buffer.sv */
`timescale 1ns/1ps
`include "spec_defines.svh"

module spectrum_buffer (
    input  logic           clk,
    input  logic           arst_n,
    input  spec_pkg::acc_t sum,
    input  spec_pkg::bin_t sum_bin,
    input  logic           sum_valid,
    input  logic           rd_en,
    input  spec_pkg::bin_t rd_addr,
    output spec_pkg::acc_t rd_data,
    output logic           rd_valid,
    output logic           spec_ready
);

    localparam spec_pkg::bin_t LAST_BIN = spec_pkg::bin_t'(`SPEC_VECTOR_LEN - 1);

    logic fill_bank;
    logic last_write;

    assign last_write = sum_valid && (sum_bin == LAST_BIN);

    // Bank bit is the top address bit.
    sdp_ram #(
        .word_t(spec_pkg::acc_t),
        .DEPTH (2 * `SPEC_VECTOR_LEN)
    ) spec_ram_inst (
        .clk    (clk),
        .wr_en  (sum_valid),
        .wr_addr({fill_bank, sum_bin}),
        .wr_data(sum),
        .rd_en  (rd_en),
        .rd_addr({~fill_bank, rd_addr}), // Host sees the completed bank.
        .rd_data(rd_data)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fill_bank  <= 1'b1; // Read bank is 0 after reset.
            spec_ready <= 1'b0;
            rd_valid   <= 1'b0;
        end else begin
            spec_ready <= last_write;
            rd_valid   <= rd_en;
            if (last_write) begin
                fill_bank <= ~fill_bank;
            end
        end
    end

endmodule

/* src/vector_acc.sv */
`timescale 1ns/1ps
`include "spec_defines.svh"

module vector_acc (
    input  logic             clk,
    input  logic             arst_n,
    input  spec_pkg::power_t pwr,
    input  logic             pwr_valid,
    input  spec_pkg::bin_t   bin,
    input  logic             first_frame,
    input  logic             last_frame,
    output spec_pkg::acc_t   sum,
    output spec_pkg::bin_t   sum_bin,
    output logic             sum_valid
);

    // Stage 1 waits on the RAM read, stage 2 holds the stored word.
    logic             valid_s1;
    logic             valid_s2;
    spec_pkg::bin_t   bin_s1;
    spec_pkg::bin_t   bin_s2;
    logic             first_s1;
    logic             first_s2;
    logic             last_s1;
    logic             last_s2;
    spec_pkg::power_t pwr_s1;
    spec_pkg::power_t pwr_s2;
    spec_pkg::acc_t   ram_q;
    spec_pkg::acc_t   stored;
    spec_pkg::acc_t   new_sum;

    sdp_ram #(
        .word_t(spec_pkg::acc_t),
        .DEPTH (`SPEC_VECTOR_LEN)
    ) acc_ram_inst (
        .clk    (clk),
        .wr_en  (valid_s2),
        .wr_addr(bin_s2),
        .wr_data(new_sum),
        .rd_en  (pwr_valid),
        .rd_addr(bin),
        .rd_data(ram_q)
    );

    // First frame of an integration starts from zero.
    assign new_sum = (first_s2 ? '0 : stored) + spec_pkg::acc_t'(pwr_s2);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_s1  <= 1'b0;
            valid_s2  <= 1'b0;
            sum_valid <= 1'b0;
        end else begin
            valid_s1  <= pwr_valid;
            valid_s2  <= valid_s1;
            sum_valid <= valid_s2 && last_s2; // Only finished sums leave.
        end
    end

    always_ff @(posedge clk) begin
        bin_s1   <= bin;
        first_s1 <= first_frame;
        last_s1  <= last_frame;
        pwr_s1   <= pwr;
        bin_s2   <= bin_s1;
        first_s2 <= first_s1;
        last_s2  <= last_s1;
        pwr_s2   <= pwr_s1;
        stored   <= ram_q;
        sum      <= new_sum;
        sum_bin  <= bin_s2;
    end

endmodule

/* src/power_calc.sv */
`timescale 1ns/1ps

module power_calc (
    input  logic              clk,
    input  logic              arst_n,
    input  spec_pkg::sample_t sample_re,
    input  spec_pkg::sample_t sample_im,
    input  logic              sample_valid,
    input  spec_pkg::bin_t    bin_in,
    input  logic              first_in,
    input  logic              last_in,
    output spec_pkg::power_t  pwr,
    output logic              pwr_valid,
    output spec_pkg::bin_t    bin,
    output logic              first_frame,
    output logic              last_frame
);

    logic                                 valid_s1;
    logic signed [2*$bits(spec_pkg::sample_t)-1:0] re_sq;
    logic signed [2*$bits(spec_pkg::sample_t)-1:0] im_sq;
    spec_pkg::bin_t                       bin_s1;
    logic                                 first_s1;
    logic                                 last_s1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_s1  <= 1'b0;
            pwr_valid <= 1'b0;
        end else begin
            valid_s1  <= sample_valid;
            pwr_valid <= valid_s1;
        end
    end

    always_ff @(posedge clk) begin
        re_sq       <= sample_re * sample_re; // Stage one.
        im_sq       <= sample_im * sample_im;
        bin_s1      <= bin_in;
        first_s1    <= first_in;
        last_s1     <= last_in;
        pwr         <= {1'b0, re_sq} + {1'b0, im_sq}; // Stage two.
        bin         <= bin_s1;
        first_frame <= first_s1;
        last_frame  <= last_s1;
    end

endmodule

/* src/frame_tracker.sv */
`timescale 1ns/1ps
`include "spec_defines.svh"

module frame_tracker (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   start,
    input  spec_pkg::frame_cnt_t   acc_len,
    input  logic                   sample_valid,
    output spec_pkg::bin_t         bin,
    output logic                   first_frame,
    output logic                   last_frame
);

    localparam spec_pkg::bin_t LAST_BIN = spec_pkg::bin_t'(`SPEC_VECTOR_LEN - 1);

    logic                 armed;
    spec_pkg::bin_t       bin_cnt;
    spec_pkg::frame_cnt_t frame_cnt;
    spec_pkg::frame_cnt_t last_idx;

    assign last_idx = acc_len - spec_pkg::frame_cnt_t'(1);

    // Flags describe the sample presented this cycle.
    assign bin         = bin_cnt;
    assign first_frame = armed && (frame_cnt == '0);
    assign last_frame  = armed && (frame_cnt == last_idx);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            armed     <= 1'b0;
            bin_cnt   <= '0;
            frame_cnt <= '0;
        end else if (start) begin
            armed     <= 1'b1; // Next sample is bin 0 of frame 0.
            bin_cnt   <= '0;
            frame_cnt <= '0;
        end else if (sample_valid) begin
            bin_cnt <= bin_cnt + 1'b1; // Wraps at VECTOR_LEN.
            if (bin_cnt == LAST_BIN) begin
                if (last_frame) begin
                    armed     <= 1'b0; // Integration complete.
                    frame_cnt <= '0;
                end else if (armed) begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* src/sdp_ram.sv */
`timescale 1ns/1ps

module sdp_ram #(
    parameter type word_t = logic [31:0],
    parameter int  DEPTH  = 16
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  word_t                    wr_data,
    input  logic                     rd_en,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output word_t                    rd_data
);

    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, holds its word while rd_en is low.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* src/spec_pkg.sv */
`include "spec_defines.svh"

package spec_pkg;

    // One signed part of a complex sample.
    typedef logic signed [`SPEC_SAMPLE_W-1:0] sample_t;

    // re^2 + im^2 needs one bit more than a single square.
    typedef logic [2*`SPEC_SAMPLE_W:0] power_t;

    // Per-bin running sum.
    typedef logic [`SPEC_ACC_W-1:0] acc_t;

    // Bin index within a frame.
    typedef logic [$clog2(`SPEC_VECTOR_LEN)-1:0] bin_t;

    // Frames per integration.
    typedef logic [`SPEC_FRAME_CNT_W-1:0] frame_cnt_t;

endpackage

/* src/spec_defines.svh */
`ifndef SPEC_DEFINES_SVH
`define SPEC_DEFINES_SVH

// Width of each signed sample part.
`define SPEC_SAMPLE_W 8

// Bins per frame, a power of two and at least 8.
`define SPEC_VECTOR_LEN 16

// Width of the integration length.
`define SPEC_FRAME_CNT_W 8

// Running sum width.
// Sized so that 255 frames of full-scale power cannot wrap.
`define SPEC_ACC_W 32

`endif
